//--- hdl/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_id_defines.svh"

module branch_unit (
    input  mips_pipe_pkg::br_kind_e  br_kind,
    input  mips_isa_pkg::word_t      pc,
    input  mips_isa_pkg::word_t      inst,
    input  mips_isa_pkg::word_t      rs_value,
    input  mips_isa_pkg::word_t      rt_value,
    input  wire                      ds_valid,
    input  wire                      ready_go,
    output mips_pipe_pkg::br_req_t   br
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    imm16_t offset;
    word_t  br_offset;
    word_t  jump_target;
    logic   rs_eq_rt;
    logic   rs_neg;
    logic   rs_zero;
    logic   cond;

    assign offset    = inst[15:0];
    assign br_offset = {{(`MIPS_XLEN-16){offset[15]}}, offset} << `MIPS_BR_SHIFT;
    // region jump keeps the upper four pc bits
    assign jump_target = {pc[`MIPS_XLEN-1:28], inst[25:0], {`MIPS_BR_SHIFT{1'b0}}};

    assign rs_eq_rt = (rs_value == rt_value);
    assign rs_neg   = rs_value[`MIPS_XLEN-1];
    assign rs_zero  = (rs_value == '0);

    always_comb begin
        case (br_kind)
            BR_BEQ:  cond = rs_eq_rt;
            BR_BNE:  cond = !rs_eq_rt;
            BR_BGEZ: cond = !rs_neg;
            BR_BGTZ: cond = !rs_neg && !rs_zero;
            BR_BLEZ: cond = rs_neg || rs_zero;
            BR_BLTZ: cond = rs_neg;
            BR_J,
            BR_JR:   cond = 1'b1;
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        case (br_kind)
            BR_JR:   br.target = rs_value;
            BR_J:    br.target = jump_target;
            default: br.target = pc + br_offset;
        endcase
        br.taken = cond && ds_valid;
        br.stall = ready_go;
    end

endmodule

`default_nettype wire

//--- hdl/decode_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module decode_ctrl (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        in_valid,
    input  mips_pipe_pkg::fetch_pkt_t  in_pkt,
    input  wire                        hazard,
    input  wire                        exec_allowin,
    output logic                       in_allowin,
    output logic                       ds_valid,
    output logic                       ready_go,
    output logic                       out_valid,
    output mips_pipe_pkg::fetch_pkt_t  held_pkt
);

    // the only thing that holds the stage back is load-use
    assign ready_go = !hazard;

    // take a new packet when empty or when the current one leaves
    assign in_allowin = !ds_valid || (ready_go && exec_allowin);

    assign out_valid = ds_valid && ready_go;

    always_ff @(posedge clk) begin
        if (rst) begin
            ds_valid <= 1'b0;
        end else if (in_allowin) begin
            ds_valid <= in_valid;
        end
    end

    // instruction register, loaded only on a handshake
    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            held_pkt <= in_pkt;
        end
    end

endmodule

`default_nettype wire

//--- hdl/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        in_valid,
    input  mips_pipe_pkg::fetch_pkt_t  in_pkt,
    input  wire                        exec_allowin,
    input  mips_pipe_pkg::fwd_src_t    es_fwd,
    input  mips_pipe_pkg::fwd_src_t    ms_fwd,
    input  mips_pipe_pkg::fwd_src_t    ws_fwd,
    input  wire                        es_load,
    input  mips_pipe_pkg::wb_req_t     wb,
    output logic                       in_allowin,
    output logic                       out_valid,
    output mips_pipe_pkg::exec_pkt_t   out_pkt,
    output mips_pipe_pkg::br_req_t     br
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    fetch_pkt_t held_pkt;
    dec_ctrl_t  ctrl;
    reg_addr_t  rs;
    reg_addr_t  rt;
    word_t      rf_rs;
    word_t      rf_rt;
    word_t      rs_value;
    word_t      rt_value;
    logic       ds_valid;
    logic       ready_go;
    logic       hazard;

    assign rs = held_pkt.inst[25:21];
    assign rt = held_pkt.inst[20:16];

    decode_ctrl ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_pkt       (in_pkt),
        .hazard       (hazard),
        .exec_allowin (exec_allowin),
        .in_allowin   (in_allowin),
        .ds_valid     (ds_valid),
        .ready_go     (ready_go),
        .out_valid    (out_valid),
        .held_pkt     (held_pkt)
    );

    inst_decoder dec_i (
        .inst (held_pkt.inst),
        .ctrl (ctrl)
    );

    reg_file rf_i (
        .clk    (clk),
        .raddr1 (rs),
        .raddr2 (rt),
        .wb     (wb),
        .rdata1 (rf_rs),
        .rdata2 (rf_rt)
    );

    operand_forward fwd_i (
        .rs       (rs),
        .rt       (rt),
        .rf_rs    (rf_rs),
        .rf_rt    (rf_rt),
        .es_fwd   (es_fwd),
        .ms_fwd   (ms_fwd),
        .ws_fwd   (ws_fwd),
        .es_load  (es_load),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .hazard   (hazard)
    );

    branch_unit br_i (
        .br_kind  (ctrl.br_kind),
        .pc       (held_pkt.pc),
        .inst     (held_pkt.inst),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .ds_valid (ds_valid),
        .ready_go (ready_go),
        .br       (br)
    );

    // packet for execute, immediate left raw for the ALU side to extend
    assign out_pkt = '{
        ctrl:     ctrl,
        imm:      held_pkt.inst[15:0],
        rs_value: rs_value,
        rt_value: rt_value,
        pc:       held_pkt.pc
    };

endmodule

`default_nettype wire

//--- hdl/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_id_defines.svh"

module inst_decoder (
    input  mips_isa_pkg::word_t       inst,
    output mips_pipe_pkg::dec_ctrl_t  ctrl
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    opcode_e   op;
    funct_e    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    logic [4:0] sa;

    assign op    = opcode_e'(inst[31:26]);
    assign funct = funct_e'(inst[5:0]);
    assign rs    = inst[25:21];
    assign rt    = inst[20:16];
    assign rd    = inst[15:11];
    assign sa    = inst[10:6];

    // register-register ALU ops by function code
    function automatic alu_op_e funct_alu(input funct_e f);
        alu_op_e res;
        case (f)
            F_SUBU:  res = ALU_SUB;
            F_SLT:   res = ALU_SLT;
            F_SLTU:  res = ALU_SLTU;
            F_AND:   res = ALU_AND;
            F_OR:    res = ALU_OR;
            F_XOR:   res = ALU_XOR;
            F_NOR:   res = ALU_NOR;
            F_SLL:   res = ALU_SLL;
            F_SRL:   res = ALU_SRL;
            F_SRA:   res = ALU_SRA;
            default: res = ALU_ADD;
        endcase
        return res;
    endfunction

    always_comb begin
        ctrl          = '0;
        ctrl.alu_op   = ALU_ADD;
        ctrl.br_kind  = BR_NONE;
        ctrl.dest     = rd;
        ctrl.reserved = 1'b1;
        case (op)
            OP_SPECIAL: begin
                case (funct)
                    F_ADDU, F_SUBU, F_SLT, F_SLTU, F_AND, F_OR, F_XOR, F_NOR: begin
                        if (sa == 5'd0) begin
                            ctrl.reserved = 1'b0;
                            ctrl.gr_we    = 1'b1;
                            ctrl.alu_op   = funct_alu(funct);
                        end
                    end
                    F_SLL, F_SRL, F_SRA: begin
                        // shift amount comes from sa, rs must be zero
                        if (rs == '0) begin
                            ctrl.reserved   = 1'b0;
                            ctrl.gr_we      = 1'b1;
                            ctrl.src1_is_sa = 1'b1;
                            ctrl.alu_op     = funct_alu(funct);
                        end
                    end
                    F_JR: begin
                        if (rt == '0 && rd == '0 && sa == 5'd0) begin
                            ctrl.reserved  = 1'b0;
                            ctrl.is_branch = 1'b1;
                            ctrl.br_kind   = BR_JR;
                        end
                    end
                    F_JALR: begin
                        // link goes to rd, return address is pc + 8
                        if (rt == '0 && sa == 5'd0) begin
                            ctrl.reserved   = 1'b0;
                            ctrl.is_branch  = 1'b1;
                            ctrl.br_kind    = BR_JR;
                            ctrl.gr_we      = 1'b1;
                            ctrl.src1_is_pc = 1'b1;
                            ctrl.src2_is_8  = 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
            OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LW: begin
                if (op != OP_LUI || rs == '0) begin
                    ctrl.reserved    = 1'b0;
                    ctrl.gr_we       = 1'b1;
                    ctrl.src2_is_imm = 1'b1;
                    ctrl.dest        = rt;
                    ctrl.load_op     = (op == OP_LW);
                    ctrl.zero_ext_imm = (op == OP_ANDI) || (op == OP_ORI) || (op == OP_XORI);
                    case (op)
                        OP_SLTI:  ctrl.alu_op = ALU_SLT;
                        OP_SLTIU: ctrl.alu_op = ALU_SLTU;
                        OP_ANDI:  ctrl.alu_op = ALU_AND;
                        OP_ORI:   ctrl.alu_op = ALU_OR;
                        OP_XORI:  ctrl.alu_op = ALU_XOR;
                        OP_LUI:   ctrl.alu_op = ALU_LUI;
                        default:  ctrl.alu_op = ALU_ADD;
                    endcase
                end
            end
            OP_SW: begin
                ctrl.reserved    = 1'b0;
                ctrl.src2_is_imm = 1'b1;
                ctrl.mem_we      = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                ctrl.reserved  = 1'b0;
                ctrl.is_branch = 1'b1;
                ctrl.br_kind   = (op == OP_BEQ) ? BR_BEQ : BR_BNE;
            end
            OP_BLEZ, OP_BGTZ: begin
                if (rt == '0) begin
                    ctrl.reserved  = 1'b0;
                    ctrl.is_branch = 1'b1;
                    ctrl.br_kind   = (op == OP_BLEZ) ? BR_BLEZ : BR_BGTZ;
                end
            end
            OP_REGIMM: begin
                // rt selects bltz (0) or bgez (1), link forms excluded
                if (rt == 5'd0 || rt == 5'd1) begin
                    ctrl.reserved  = 1'b0;
                    ctrl.is_branch = 1'b1;
                    ctrl.br_kind   = rt[0] ? BR_BGEZ : BR_BLTZ;
                end
            end
            OP_J, OP_JAL: begin
                ctrl.reserved  = 1'b0;
                ctrl.is_branch = 1'b1;
                ctrl.br_kind   = BR_J;
                if (op == OP_JAL) begin
                    ctrl.gr_we      = 1'b1;
                    ctrl.src1_is_pc = 1'b1;
                    ctrl.src2_is_8  = 1'b1;
                    ctrl.dest       = reg_addr_t'(`MIPS_LINK_REG);
                end
            end
            default: ;
        endcase
        // nothing outside the subset may write a register
        ctrl.gr_we = ctrl.gr_we & ~ctrl.reserved;
    end

endmodule

`default_nettype wire

//--- hdl/mips_id_defines.svh
`ifndef MIPS_ID_DEFINES_SVH
`define MIPS_ID_DEFINES_SVH

// machine word width
`define MIPS_XLEN 32

// general purpose registers
`define MIPS_REG_CNT 32

// jal writes its return address here
`define MIPS_LINK_REG 31

// branch offsets and jump indexes count words
`define MIPS_BR_SHIFT 2

`endif

//--- hdl/mips_isa_pkg.sv
`default_nettype none

`include "mips_id_defines.svh"

package mips_isa_pkg;

    typedef logic [`MIPS_XLEN-1:0] word_t;
    typedef logic [$clog2(`MIPS_REG_CNT)-1:0] reg_addr_t;
    typedef logic [15:0] imm16_t;

    // primary opcodes of the supported subset
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_REGIMM  = 6'h01,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_BLEZ    = 6'h06,
        OP_BGTZ    = 6'h07,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // function field under SPECIAL
    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_SRA  = 6'h03,
        F_JR   = 6'h08,
        F_JALR = 6'h09,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_NOR  = 6'h27,
        F_SLT  = 6'h2a,
        F_SLTU = 6'h2b
    } funct_e;

    // execute stage operation, binary encoded
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_NOR,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

endpackage

`default_nettype wire

//--- hdl/mips_pipe_pkg.sv
`default_nettype none

package mips_pipe_pkg;

    // packet from fetch
    typedef struct packed {
        mips_isa_pkg::word_t pc;
        mips_isa_pkg::word_t inst;
    } fetch_pkt_t;

    // result bypass from a later stage
    typedef struct packed {
        logic                    valid;
        logic                    we;
        mips_isa_pkg::reg_addr_t addr;
        mips_isa_pkg::word_t     data;
    } fwd_src_t;

    // register file write from writeback
    typedef struct packed {
        logic                    we;
        mips_isa_pkg::reg_addr_t addr;
        mips_isa_pkg::word_t     data;
    } wb_req_t;

    // shared by decoder and branch unit
    typedef enum logic [3:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BGEZ,
        BR_BGTZ,
        BR_BLEZ,
        BR_BLTZ,
        BR_J,
        BR_JR
    } br_kind_e;

    typedef struct packed {
        mips_isa_pkg::alu_op_e   alu_op;
        logic                    src1_is_sa;
        logic                    src1_is_pc;
        logic                    src2_is_imm;
        logic                    src2_is_8;
        logic                    zero_ext_imm;
        logic                    gr_we;
        logic                    mem_we;
        logic                    load_op;
        mips_isa_pkg::reg_addr_t dest;
        logic                    is_branch;
        br_kind_e                br_kind;
        logic                    reserved;
    } dec_ctrl_t;

    // handed to execute
    typedef struct packed {
        dec_ctrl_t            ctrl;
        mips_isa_pkg::imm16_t imm;
        mips_isa_pkg::word_t  rs_value;
        mips_isa_pkg::word_t  rt_value;
        mips_isa_pkg::word_t  pc;
    } exec_pkt_t;

    // redirect request to fetch
    typedef struct packed {
        logic                taken;
        logic                stall;
        mips_isa_pkg::word_t target;
    } br_req_t;

endpackage

`default_nettype wire

//--- hdl/operand_forward.sv
`timescale 1ns/1ps
`default_nettype none

module operand_forward (
    input  mips_isa_pkg::reg_addr_t  rs,
    input  mips_isa_pkg::reg_addr_t  rt,
    input  mips_isa_pkg::word_t      rf_rs,
    input  mips_isa_pkg::word_t      rf_rt,
    input  mips_pipe_pkg::fwd_src_t  es_fwd,
    input  mips_pipe_pkg::fwd_src_t  ms_fwd,
    input  mips_pipe_pkg::fwd_src_t  ws_fwd,
    input  wire                      es_load,
    output mips_isa_pkg::word_t      rs_value,
    output mips_isa_pkg::word_t      rt_value,
    output logic                     hazard
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    logic es_hit_rs;
    logic es_hit_rt;

    function automatic logic src_match(input fwd_src_t src, input reg_addr_t addr);
        return src.valid && src.we && (src.addr == addr);
    endfunction

    // youngest producer wins, a load in execute has no data yet
    function automatic word_t pick(input reg_addr_t addr, input word_t rf_val);
        word_t res;
        if (addr == '0) begin
            res = '0;
        end else if (src_match(es_fwd, addr) && !es_load) begin
            res = es_fwd.data;
        end else if (src_match(ms_fwd, addr)) begin
            res = ms_fwd.data;
        end else if (src_match(ws_fwd, addr)) begin
            res = ws_fwd.data;
        end else begin
            res = rf_val;
        end
        return res;
    endfunction

    always_comb begin
        rs_value = pick(rs, rf_rs);
        rt_value = pick(rt, rf_rt);
    end

    // load-use, both sources checked whether rt is read or not
    assign es_hit_rs = (rs != '0) && (rs == es_fwd.addr);
    assign es_hit_rt = (rt != '0) && (rt == es_fwd.addr);
    assign hazard    = es_fwd.valid && es_load && (es_hit_rs || es_hit_rt);

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_id_defines.svh"

module reg_file (
    input  wire                      clk,
    input  mips_isa_pkg::reg_addr_t  raddr1,
    input  mips_isa_pkg::reg_addr_t  raddr2,
    input  mips_pipe_pkg::wb_req_t   wb,
    output mips_isa_pkg::word_t      rdata1,
    output mips_isa_pkg::word_t      rdata2
);
    import mips_isa_pkg::*;

    word_t regs [`MIPS_REG_CNT];

    // register 0 is never written
    always_ff @(posedge clk) begin
        if (wb.we && wb.addr != '0) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // combinational reads, r0 hardwired to zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- mips_id.f
+incdir+hdl
hdl/mips_isa_pkg.sv
hdl/mips_pipe_pkg.sv
hdl/inst_decoder.sv
hdl/reg_file.sv
hdl/operand_forward.sv
hdl/branch_unit.sv
hdl/decode_ctrl.sv
hdl/id_stage.sv
testbench/id_stage_chk.sv
testbench/tb_id_stage.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_id_stage \
    -f mips_id.f \
    -o sim_id_stage
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_id_stage)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Done: no errors"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

//--- testbench/id_stage_chk.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage_chk (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       in_valid,
    input  wire                       in_allowin,
    input  wire                       exec_allowin,
    input  wire                       out_valid,
    input  mips_pipe_pkg::exec_pkt_t  out_pkt,
    input  mips_pipe_pkg::br_req_t    br
);
    import mips_pipe_pkg::*;

    // set once the first fetch packet has been taken
    logic seen_pkt;

    always_ff @(posedge clk) begin
        if (rst) begin
            seen_pkt <= 1'b0;
        end else if (in_valid && in_allowin) begin
            seen_pkt <= 1'b1;
        end
    end

    quiet_until_first_pkt: assert property (@(posedge clk)
        !seen_pkt |-> (!out_valid && !br.taken))
        else $error("output active before any packet was taken");

    pkt_held_under_backpressure: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !exec_allowin) |=> $stable(out_pkt))
        else $error("out_pkt changed while execute held it back");

    no_allowin_under_backpressure: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !exec_allowin) |-> !in_allowin)
        else $error("in_allowin high while execute held the stage");

    // taken with no output only during a load-use stall
    taken_needs_valid: assert property (@(posedge clk) disable iff (rst)
        br.taken |-> (out_valid || !br.stall))
        else $error("branch taken without a valid packet");

endmodule

bind id_stage id_stage_chk chk_i (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (in_valid),
    .in_allowin   (in_allowin),
    .exec_allowin (exec_allowin),
    .out_valid    (out_valid),
    .out_pkt      (out_pkt),
    .br           (br)
);

`default_nettype wire

//--- testbench/tb_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    logic       clk;
    logic       rst;
    logic       in_valid;
    logic       exec_allowin;
    logic       es_load;
    logic       in_allowin;
    logic       out_valid;
    fetch_pkt_t in_pkt;
    fwd_src_t   es_fwd;
    fwd_src_t   ms_fwd;
    fwd_src_t   ws_fwd;
    wb_req_t    wb;
    exec_pkt_t  out_pkt;
    br_req_t    br;

    integer seed = 32'h0e9ae9e8;
    integer errors = 0;
    integer test_err = 0;
    integer tests_run = 0;
    integer tests_failed = 0;
    word_t  vals [0:4];
    word_t  bpc = 32'h1040_2000;

    // R-type and I-type forms for the decode sample
    logic [5:0] r_funct [0:10] = '{6'h21, 6'h23, 6'h2a, 6'h2b, 6'h24, 6'h25,
                                   6'h26, 6'h27, 6'h00, 6'h02, 6'h03};
    alu_op_e    r_alu [0:10] = '{ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR,
                                 ALU_XOR, ALU_NOR, ALU_SLL, ALU_SRL, ALU_SRA};
    logic [5:0] i_op [0:8] = '{6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f,
                               6'h23, 6'h2b};
    alu_op_e    i_alu [0:8] = '{ALU_ADD, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR, ALU_XOR,
                                ALU_LUI, ALU_ADD, ALU_ADD};

    id_stage dut_i (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_pkt       (in_pkt),
        .exec_allowin (exec_allowin),
        .es_fwd       (es_fwd),
        .ms_fwd       (ms_fwd),
        .ws_fwd       (ws_fwd),
        .es_load      (es_load),
        .wb           (wb),
        .in_allowin   (in_allowin),
        .out_valid    (out_valid),
        .out_pkt      (out_pkt),
        .br           (br)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic word_t r_type(input logic [5:0] f, input reg_addr_t s,
                                     input reg_addr_t t, input reg_addr_t d,
                                     input logic [4:0] sh);
        return {6'h00, s, t, d, sh, f};
    endfunction

    function automatic word_t i_type(input logic [5:0] op, input reg_addr_t s,
                                     input reg_addr_t t, input imm16_t imm);
        return {op, s, t, imm};
    endfunction

    function automatic fwd_src_t mk_fwd(input reg_addr_t a, input word_t d);
        return '{valid: 1'b1, we: 1'b1, addr: a, data: d};
    endfunction

    // pc relative target of a conditional branch
    function automatic word_t br_dest(input imm16_t o);
        return bpc + {{14{o[15]}}, o, 2'b00};
    endfunction

    task automatic check(input logic ok, input string msg);
        assert (ok) else begin
            $display("Fail at %0d ns: %s", $time, msg);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_err) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - test_err);
            tests_failed++;
        end
        test_err = errors;
    endtask

    task automatic write_reg(input reg_addr_t a, input word_t d);
        @(negedge clk);
        wb = '{we: 1'b1, addr: a, data: d};
        @(negedge clk);
        wb = '0;
    endtask

    task automatic send_pkt(input word_t pc, input word_t inst);
        integer n;
        n = 0;
        @(negedge clk);
        in_valid = 1'b1;
        in_pkt = '{pc: pc, inst: inst};
        #1;
        while (!in_allowin && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!in_allowin) begin
            $display("timeout waiting for in_allowin");
            errors++;
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_out_valid();
        integer n;
        n = 0;
        #1;
        while (!out_valid && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!out_valid) begin
            $display("timeout waiting for out_valid");
            errors++;
        end
    endtask

    task automatic issue(input word_t inst);
        send_pkt(bpc, inst);
        wait_out_valid();
    endtask

    task automatic expect_stall(input integer cycles);
        repeat (cycles) begin
            check(!out_valid, "out_valid high during load-use stall");
            check(!in_allowin, "in_allowin high during load-use stall");
            check(!br.stall, "br.stall high during load-use stall");
            @(negedge clk);
        end
    endtask

    task automatic br_case(input word_t inst, input logic taken, input word_t target,
                           input string msg);
        issue(inst);
        check(br.taken == taken, {msg, ": wrong taken"});
        check(br.target == target, {msg, ": wrong target"});
        check(out_pkt.ctrl.is_branch, {msg, ": is_branch low"});
        check(br.stall, {msg, ": br.stall low without a hazard"});
    endtask

    task automatic decode_sample();
        integer  k;
        word_t   r;
        word_t   inst;
        alu_op_e alu;
        logic    is_r;
        r = $random(seed);
        k = {$random(seed)} % 20;
        is_r = (k < 11);
        if (is_r) begin
            // shifts need rs zero, others need sa zero
            inst = r_type(r_funct[k], (k >= 8) ? 5'd0 : r[4:0], r[9:5], r[14:10],
                          (k >= 8) ? r[19:15] : 5'd0);
            alu = r_alu[k];
        end else begin
            inst = i_type(i_op[k-11], (k == 17) ? 5'd0 : r[4:0], r[9:5], r[31:16]);
            alu = i_alu[k-11];
        end
        issue(inst);
        check(out_pkt.ctrl.alu_op == alu, "decode alu_op");
        check(out_pkt.ctrl.src1_is_sa == (k >= 8 && k <= 10), "decode src1_is_sa");
        check(!out_pkt.ctrl.src1_is_pc && !out_pkt.ctrl.src2_is_8, "decode link selectors");
        check(out_pkt.ctrl.src2_is_imm == !is_r, "decode src2_is_imm");
        check(out_pkt.ctrl.zero_ext_imm == (k >= 14 && k <= 16), "decode zero_ext_imm");
        check(out_pkt.ctrl.gr_we == (k != 19), "decode gr_we");
        check(out_pkt.ctrl.mem_we == (k == 19), "decode mem_we");
        check(out_pkt.ctrl.load_op == (k == 18), "decode load_op");
        check(!out_pkt.ctrl.is_branch, "decode is_branch");
        if (k != 19) begin
            check(out_pkt.ctrl.dest == (is_r ? inst[15:11] : inst[20:16]), "decode dest");
        end
        check(out_pkt.imm == inst[15:0], "decode imm");
        check(!out_pkt.ctrl.reserved, "subset encoding marked reserved");
    endtask

    initial begin
        fetch_pkt_t pkt_b;
        exec_pkt_t  snap;
        word_t      v;
        rst = 1'b1;
        in_valid = 1'b0;
        in_pkt = '0;
        exec_allowin = 1'b1;
        es_load = 1'b0;
        es_fwd = '0;
        ms_fwd = '0;
        ws_fwd = '0;
        wb = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // register file and r0
        for (int i = 1; i < 5; i++) begin
            vals[i] = $random(seed);
            write_reg(i[4:0], vals[i]);
        end
        write_reg(5'd0, $random(seed));
        issue(r_type(6'h21, 5'd1, 5'd2, 5'd3, 5'd0));
        check(out_pkt.rs_value == vals[1] && out_pkt.rt_value == vals[2], "rf read r1 r2");
        issue(r_type(6'h21, 5'd3, 5'd4, 5'd3, 5'd0));
        check(out_pkt.rs_value == vals[3] && out_pkt.rt_value == vals[4], "rf read r3 r4");
        issue(r_type(6'h21, 5'd0, 5'd4, 5'd3, 5'd0));
        check(out_pkt.rs_value == '0, "r0 not zero after write");
        end_test("register file");

        // forwarding priority on r5
        v = $random(seed);
        write_reg(5'd5, v);
        ws_fwd = mk_fwd(5'd5, 32'h0000_0a0a);
        issue(r_type(6'h21, 5'd5, 5'd0, 5'd1, 5'd0));
        check(out_pkt.rs_value == 32'h0000_0a0a, "writeback over file");
        ms_fwd = mk_fwd(5'd5, 32'h0000_0b0b);
        issue(r_type(6'h21, 5'd5, 5'd0, 5'd1, 5'd0));
        check(out_pkt.rs_value == 32'h0000_0b0b, "memory over writeback");
        es_fwd = mk_fwd(5'd5, 32'h0000_0c0c);
        issue(r_type(6'h21, 5'd5, 5'd0, 5'd1, 5'd0));
        check(out_pkt.rs_value == 32'h0000_0c0c, "execute over memory");
        // previous packet leaves first
        @(negedge clk);
        es_load = 1'b1;
        send_pkt(bpc, r_type(6'h21, 5'd5, 5'd0, 5'd1, 5'd0));
        expect_stall(3);
        es_load = 1'b0;
        wait_out_valid();
        check(out_pkt.rs_value == 32'h0000_0c0c, "execute value after load cleared");
        es_fwd = '0;
        ms_fwd = '0;
        ws_fwd = '0;
        issue(r_type(6'h21, 5'd5, 5'd0, 5'd1, 5'd0));
        check(out_pkt.rs_value == v, "file value with no bypass");
        end_test("forwarding");

        // load-use stall on rt, then release
        write_reg(5'd6, 32'h1357_9bdf);
        es_fwd = mk_fwd(5'd6, 32'hdead_0006);
        es_load = 1'b1;
        send_pkt(bpc + 32'h40, r_type(6'h21, 5'd0, 5'd6, 5'd2, 5'd0));
        expect_stall(4);
        es_fwd.valid = 1'b0;
        wait_out_valid();
        check(out_pkt.pc == bpc + 32'h40, "released packet has wrong pc");
        check(out_pkt.imm == 16'h1021, "released packet has wrong instruction");
        check(out_pkt.rt_value == 32'h1357_9bdf, "released packet has wrong rt_value");
        es_load = 1'b0;
        es_fwd = '0;
        end_test("load-use stall");

        // branches: r8 = r9 = 5, r10 negative, r11 zero, r12 = 7
        write_reg(5'd8, 32'd5);
        write_reg(5'd9, 32'd5);
        write_reg(5'd10, 32'hffff_fffd);
        write_reg(5'd11, 32'd0);
        write_reg(5'd12, 32'd7);
        br_case(i_type(6'h04, 5'd8, 5'd9, 16'hfff0), 1'b1, br_dest(16'hfff0), "beq equal");
        br_case(i_type(6'h04, 5'd8, 5'd12, 16'h0010), 1'b0, br_dest(16'h0010), "beq differ");
        br_case(i_type(6'h05, 5'd8, 5'd12, 16'h0010), 1'b1, br_dest(16'h0010), "bne");
        br_case(i_type(6'h01, 5'd11, 5'd1, 16'h0020), 1'b1, br_dest(16'h0020), "bgez zero");
        br_case(i_type(6'h01, 5'd10, 5'd1, 16'h0020), 1'b0, br_dest(16'h0020), "bgez neg");
        br_case(i_type(6'h07, 5'd11, 5'd0, 16'h0030), 1'b0, br_dest(16'h0030), "bgtz zero");
        br_case(i_type(6'h07, 5'd12, 5'd0, 16'h0030), 1'b1, br_dest(16'h0030), "bgtz pos");
        br_case(i_type(6'h06, 5'd11, 5'd0, 16'hff00), 1'b1, br_dest(16'hff00), "blez zero");
        br_case(i_type(6'h06, 5'd12, 5'd0, 16'hff00), 1'b0, br_dest(16'hff00), "blez pos");
        br_case(i_type(6'h01, 5'd10, 5'd0, 16'h0004), 1'b1, br_dest(16'h0004), "bltz neg");
        br_case({6'h02, 26'h012_3456}, 1'b1, {bpc[31:28], 26'h012_3456, 2'b00}, "j");
        br_case({6'h03, 26'h3ab_cdef}, 1'b1, {bpc[31:28], 26'h3ab_cdef, 2'b00}, "jal");
        check(out_pkt.ctrl.dest == 5'd31, "jal dest not 31");
        check(out_pkt.ctrl.src1_is_pc && out_pkt.ctrl.src2_is_8, "jal link selectors");
        br_case(r_type(6'h08, 5'd12, 5'd0, 5'd0, 5'd0), 1'b1, 32'd7, "jr");
        end_test("branches");

        // decode fields, then encodings outside the subset
        repeat (16) decode_sample();
        issue(i_type(6'h3f, 5'd1, 5'd2, 16'h1234));
        check(out_pkt.ctrl.reserved && !out_pkt.ctrl.gr_we, "unknown opcode not reserved");
        issue(r_type(6'h21, 5'd1, 5'd2, 5'd3, 5'd4));
        check(out_pkt.ctrl.reserved && !out_pkt.ctrl.gr_we, "addu with sa not reserved");
        end_test("decode");

        // back-pressure holds the first packet and blocks the second
        @(negedge clk);
        exec_allowin = 1'b0;
        send_pkt(32'h0000_1000, r_type(6'h21, 5'd1, 5'd2, 5'd3, 5'd0));
        wait_out_valid();
        snap = out_pkt;
        pkt_b = '{pc: 32'h0000_2000, inst: r_type(6'h25, 5'd3, 5'd4, 5'd5, 5'd0)};
        in_valid = 1'b1;
        in_pkt = pkt_b;
        repeat (3) begin
            @(negedge clk);
            check(out_valid && out_pkt == snap, "held packet changed");
            check(!in_allowin, "second packet could enter");
        end
        exec_allowin = 1'b1;
        @(negedge clk);
        in_valid = 1'b0;
        wait_out_valid();
        check(out_pkt.pc == pkt_b.pc, "second packet not next in order");
        @(negedge clk);
        check(!out_valid, "second packet appeared twice");
        end_test("back-pressure");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
